//--- wq_manager.f
common/wq_pkg.sv
rtl/sq_doorbell.sv
rtl/qp_config.sv
wqe_fetch/wqe_fetch.sv
sq_segmenter/sq_segmenter.sv
rtl/wq_manager.sv
testbench/tb_clock_gen.sv
testbench/tb_wqe_mem.sv
testbench/tb_wq_manager.sv

//--- Bender.yml
package:
  name: wq_manager

sources:
  - common/wq_pkg.sv
  - rtl/sq_doorbell.sv
  - rtl/qp_config.sv
  - wqe_fetch/wqe_fetch.sv
  - sq_segmenter/sq_segmenter.sv
  - rtl/wq_manager.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_wqe_mem.sv
      - testbench/tb_wq_manager.sv

//--- testbench/tb_wq_manager.sv
module tb_wq_manager;

  import wq_pkg::*;

  localparam logic [ADDR_W-1:0] MEM_BASE   = 64'h0000_0040_0000_0000;
  localparam int                MAX_CYCLES = 20000;  // Whole run needs well under 1000

  logic                clk;
  logic                rstn;
  logic [QP_IDX_W-1:0] qp_idx;
  logic [IDX_W-1:0]    sq_prod_idx;
  logic [ADDR_W-1:0]   sq_base_addr;
  logic [ADDR_W-1:0]   local_vaddr;
  logic                qp_configured;
  logic [31:0]         qp_conf;
  logic [QPN_W-1:0]    dest_qp;
  logic [PSN_W-1:0]    sq_psn;
  logic [PSN_W-1:0]    dest_sq_psn;
  logic                arvalid;
  logic                arready;
  logic [ADDR_W-1:0]   araddr;
  logic                rvalid;
  logic [WQE_W-1:0]    rdata;
  logic                rlast;
  logic                rready;
  logic                sq_req_valid;
  logic                sq_req_ready;
  rdma_req_t           sq_req;
  logic                qp_ctx_valid;
  logic                qp_ctx_ready;
  qp_ctx_t             qp_ctx;

  rdma_req_t   exp_q [$];                  // Requests still expected, in order
  rdma_req_t   exp_req;
  rdma_req_t   held_req;
  logic        held;
  logic        bp_en;
  logic [31:0] lcg_state = 32'd65;
  int          err_cnt;
  int          chk_cnt;
  int          cycle_cnt;

  tb_clock_gen clk0 (.clk_o(clk), .rstn_o(rstn));

  tb_wqe_mem #(.BASE_ADDR(MEM_BASE), .DEPTH(64)) mem0 (
    .clk_i(clk), .rstn_i(rstn), .arvalid_i(arvalid), .arready_o(arready),
    .araddr_i(araddr), .rvalid_o(rvalid), .rdata_o(rdata), .rlast_o(rlast),
    .rready_i(rready)
  );

  wq_manager dut0 (
    .axil_aclk_i(clk), .rstn_i(rstn), .qp_idx_i(qp_idx), .sq_prod_idx_i(sq_prod_idx),
    .sq_base_addr_i(sq_base_addr), .local_vaddr_i(local_vaddr),
    .qp_configured_i(qp_configured), .qp_conf_i(qp_conf), .dest_qp_i(dest_qp),
    .sq_psn_i(sq_psn), .dest_sq_psn_i(dest_sq_psn), .arvalid_o(arvalid),
    .arready_i(arready), .araddr_o(araddr), .rvalid_i(rvalid), .rdata_i(rdata),
    .rlast_i(rlast), .rready_o(rready), .sq_req_valid_o(sq_req_valid),
    .sq_req_ready_i(sq_req_ready), .sq_req_o(sq_req), .qp_ctx_valid_o(qp_ctx_valid),
    .qp_ctx_ready_i(qp_ctx_ready), .qp_ctx_o(qp_ctx)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [ADDR_W-1:0] qp_base(input int qp);
    return MEM_BASE + ADDR_W'(qp * 8 * WQE_BYTES);   // 8 WQE slots per QP
  endfunction

  function automatic logic [31:0] conf_word(input logic en, input logic [2:0] code);
    return (32'(code) << QP_CONF_MTU_LSB) | (32'(en) << QP_CONF_EN_BIT);
  endfunction

  task automatic compare_hex(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic put_wqe(input int idx, input logic [7:0] op, input logic [31:0] len,
                         input logic [63:0] rva);
    logic [WQE_W-1:0] w;
    w = {16{32'h1357_9bdf}};               // Noise in the unused fields
    w[WQE_OP_MSB:WQE_OP_LSB]   = op;
    w[WQE_LEN_MSB:WQE_LEN_LSB] = len;
    w[WQE_RVA_MSB:WQE_RVA_LSB] = rva;
    mem0.wqe_tab[idx] = w;
  endtask

  task automatic expect_req(input logic [4:0] op, input logic last, input logic [31:0] len,
                            input logic [63:0] lva, input logic [63:0] rva);
    rdma_req_t r;
    r.opcode       = op;
    r.last         = last;
    r.len          = len;
    r.local_vaddr  = lva;
    r.remote_vaddr = rva;
    exp_q.push_back(r);
  endtask

  task automatic apply_config(input logic [7:0] qp, input logic [31:0] conf,
                              input logic [23:0] dqp, input logic [23:0] psn,
                              input logic [23:0] dpsn);
    @(posedge clk);
    qp_idx        <= qp;
    qp_conf       <= conf;
    dest_qp       <= dqp;
    sq_psn        <= psn;
    dest_sq_psn   <= dpsn;
    qp_configured <= 1'b1;
    @(posedge clk);
    qp_configured <= 1'b0;
  endtask

  // Configure and take the context right away
  task automatic configure_mtu(input logic [2:0] code);
    apply_config(8'd0, conf_word(1'b1, code), 24'h1, 24'h2, 24'h3);
    qp_ctx_ready <= 1'b1;
    @(posedge clk);
    qp_ctx_ready <= 1'b0;
  endtask

  task automatic ring_doorbell(input logic [7:0] qp, input logic [31:0] prod,
                               input logic [63:0] lva);
    @(posedge clk);
    qp_idx       <= qp;
    sq_prod_idx  <= prod;
    sq_base_addr <= qp_base(qp);
    local_vaddr  <= lva;
  endtask

  // Wait for every expected request, then let the doorbell go idle
  task automatic finish_job();
    while (exp_q.size() != 0) @(posedge clk);
    wait_cycles(8);
    sq_prod_idx <= '0;
    wait_cycles(2);
  endtask

  task automatic check_fetches(input int first, input int n, input logic [63:0] base);
    if (mem0.ar_cnt - first != n) begin
      $display("Expected %0d WQE fetches but saw %0d", n, mem0.ar_cnt - first);
      err_cnt++;
    end
    for (int k = 0; k < n; k++) begin
      compare_hex("araddr_o", mem0.ar_log[first + k], base + 64'(k * WQE_BYTES));
    end
  endtask

  task automatic check_ctx(input qp_ctx_t exp);
    compare_hex("qp_ctx_o.qp_idx", qp_ctx.qp_idx, exp.qp_idx);
    compare_hex("qp_ctx_o.dest_qp", qp_ctx.dest_qp, exp.dest_qp);
    compare_hex("qp_ctx_o.sq_psn", qp_ctx.sq_psn, exp.sq_psn);
    compare_hex("qp_ctx_o.dest_sq_psn", qp_ctx.dest_sq_psn, exp.dest_sq_psn);
    compare_hex("qp_ctx_o.mtu_code", qp_ctx.mtu_code, exp.mtu_code);
  endtask

  // A rejected strobe must leave the context port quiet
  task automatic expect_no_ctx(input string what);
    int seen;
    seen = 0;
    repeat (4) begin
      @(posedge clk);
      if (qp_ctx_valid) begin
        seen++;
      end
    end
    chk_cnt++;
    if (seen != 0) begin
      $display("Context valid was raised for a configuration with %s", what);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic config_context();
    qp_ctx_t exp;
    exp.qp_idx      = 8'd3;
    exp.dest_qp     = 24'h00abcd;
    exp.sq_psn      = 24'h012345;
    exp.dest_sq_psn = 24'h0fedcb;
    exp.mtu_code    = 3'd2;
    apply_config(exp.qp_idx, conf_word(1'b1, exp.mtu_code), exp.dest_qp, exp.sq_psn,
                 exp.dest_sq_psn);
    while (!qp_ctx_valid) @(posedge clk);
    check_ctx(exp);
    repeat (3) begin                       // Ready low, context must hold
      @(posedge clk);
      compare_hex("qp_ctx_valid_o", qp_ctx_valid, 1'b1);
      check_ctx(exp);
    end
    qp_ctx_ready <= 1'b1;
    @(posedge clk);
    qp_ctx_ready <= 1'b0;
    @(posedge clk);
    compare_hex("qp_ctx_valid_o", qp_ctx_valid, 1'b0);
    apply_config(8'd4, conf_word(1'b0, 3'd1), 24'h1, 24'h2, 24'h3);
    expect_no_ctx("enable 0");
    apply_config(8'd4, conf_word(1'b1, 3'd5), 24'h1, 24'h2, 24'h3);
    expect_no_ctx("MTU code 5");
  endtask

  task automatic short_write();
    int          first;
    logic [63:0] lva;
    logic [63:0] rva;
    lva = 64'h0000_0000_8000_1000;
    rva = 64'h0000_7f00_0000_2000;
    configure_mtu(3'd0);                   // 256 bytes
    put_wqe(0, WQE_OP_WRITE, 32'd200, rva);
    expect_req(REQ_WRITE_ONLY, 1'b1, 32'd200, lva, rva);
    first = mem0.ar_cnt;
    ring_doorbell(8'd0, 32'd1, lva);
    finish_job();
    check_fetches(first, 1, qp_base(0));
  endtask

  task automatic segmented_write();
    int          first;
    logic [63:0] lva;
    logic [63:0] rva;
    lva = 64'h0000_0000_8000_4000;
    rva = 64'h0000_7f00_0001_0000;
    configure_mtu(3'd1);                   // 512 bytes
    put_wqe(1, WQE_OP_WRITE, 32'd1300, rva);
    expect_req(REQ_WRITE_FIRST, 1'b0, 32'd512, lva, rva);
    expect_req(REQ_WRITE_MIDDLE, 1'b0, 32'd512, lva + 64'd512, rva + 64'd512);
    expect_req(REQ_WRITE_LAST, 1'b1, 32'd276, lva + 64'd1024, rva + 64'd1024);
    bp_en <= 1'b1;
    first = mem0.ar_cnt;
    ring_doorbell(8'd0, 32'd2, lva);
    finish_job();
    bp_en <= 1'b0;
    check_fetches(first, 1, qp_base(0) + 64'd64);
  endtask

  task automatic single_read();
    int          first;
    logic [63:0] lva;
    logic [63:0] rva;
    lva = 64'h0000_0000_8000_8000;
    rva = 64'h0000_7f00_0002_0000;
    put_wqe(2, WQE_OP_READ, 32'd5000, rva);
    expect_req(REQ_READ, 1'b1, 32'd5000, lva, rva);  // Never split by the MTU
    first = mem0.ar_cnt;
    ring_doorbell(8'd0, 32'd3, lva);
    finish_job();
    check_fetches(first, 1, qp_base(0) + 64'd128);
  endtask

  task automatic several_wqes_and_qps();
    int          first;
    logic [63:0] lva;
    logic [63:0] rva;
    lva = 64'h0000_0000_9000_0000;
    rva = 64'h0000_7f00_0003_0000;
    put_wqe(16, WQE_OP_READ, 32'd100, rva);
    put_wqe(17, 8'h02, 32'd64, rva + 64'h100);   // Consumed silently
    put_wqe(18, WQE_OP_READ, 32'd300, rva + 64'h200);
    expect_req(REQ_READ, 1'b1, 32'd100, lva, rva);
    expect_req(REQ_READ, 1'b1, 32'd300, lva, rva + 64'h200);
    first = mem0.ar_cnt;
    ring_doorbell(8'd2, 32'd3, lva);
    finish_job();
    check_fetches(first, 3, qp_base(2));
    // QP 5 has its own index, still at 0
    put_wqe(40, WQE_OP_READ, 32'd40, rva + 64'h300);
    expect_req(REQ_READ, 1'b1, 32'd40, lva + 64'h40, rva + 64'h300);
    first = mem0.ar_cnt;
    ring_doorbell(8'd5, 32'd1, lva + 64'h40);
    finish_job();
    check_fetches(first, 1, qp_base(5));
  endtask

  ////////////////////////////////////////
  // Request monitor and ready driver
  ////////////////////////////////////////
  always @(posedge clk) begin
    if (rstn) begin
      if (held) begin
        if (!sq_req_valid) begin
          $display("Request valid dropped before the request was accepted");
          err_cnt++;
        end else if (sq_req !== held_req) begin
          $display("[ERROR] sq_req_o got 0x%0h expected 0x%0h", sq_req, held_req);
          err_cnt++;
        end
      end
      if (sq_req_valid && sq_req_ready) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected request with opcode 0x%0h", sq_req.opcode);
          err_cnt++;
        end else begin
          exp_req = exp_q.pop_front();
          compare_hex("sq_req_o.opcode", sq_req.opcode, exp_req.opcode);
          compare_hex("sq_req_o.last", sq_req.last, exp_req.last);
          compare_hex("sq_req_o.len", sq_req.len, exp_req.len);
          compare_hex("sq_req_o.local_vaddr", sq_req.local_vaddr, exp_req.local_vaddr);
          compare_hex("sq_req_o.remote_vaddr", sq_req.remote_vaddr, exp_req.remote_vaddr);
        end
      end
      held      = sq_req_valid && !sq_req_ready;
      held_req  = sq_req;
      lcg_state = lcg_next(lcg_state);
      sq_req_ready <= bp_en ? lcg_state[16] : 1'b1;
    end
  end

  // Cycle limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, checks %0d, errors %0d",
               cycle_cnt, chk_cnt, err_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    qp_idx        <= '0;
    sq_prod_idx   <= '0;
    sq_base_addr  <= '0;
    local_vaddr   <= '0;
    qp_configured <= 1'b0;
    qp_conf       <= '0;
    dest_qp       <= '0;
    sq_psn        <= '0;
    dest_sq_psn   <= '0;
    sq_req_ready  <= 1'b0;
    qp_ctx_ready  <= 1'b0;
    bp_en         <= 1'b0;
    held          = 1'b0;
    err_cnt       = 0;
    chk_cnt       = 0;
    cycle_cnt     = 0;
    wait (rstn);
    @(posedge clk);
    // Quiet outputs out of reset
    compare_hex("arvalid_o", arvalid, 1'b0);
    compare_hex("rready_o", rready, 1'b0);
    compare_hex("sq_req_valid_o", sq_req_valid, 1'b0);
    compare_hex("qp_ctx_valid_o", qp_ctx_valid, 1'b0);
    config_context();
    short_write();
    segmented_write();
    single_read();
    several_wqes_and_qps();
    $display("Checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- testbench/tb_wqe_mem.sv
module tb_wqe_mem #(
  parameter logic [63:0] BASE_ADDR = 64'h0000_0040_0000_0000,
  parameter int          DEPTH     = 64
) (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  logic                      arvalid_i,
  output logic                      arready_o,
  input  logic [wq_pkg::ADDR_W-1:0] araddr_i,
  output logic                      rvalid_o,
  output logic [wq_pkg::WQE_W-1:0]  rdata_o,
  output logic                      rlast_o,
  input  logic                      rready_i
);

  import wq_pkg::*;

  logic [WQE_W-1:0]  wqe_tab [DEPTH];      // Loaded by the tests
  logic [ADDR_W-1:0] ar_log  [DEPTH];      // Every accepted araddr
  int                ar_cnt;
  int                resp_cnt;

  initial begin : responder
    int                delay;
    int                idx;
    logic [ADDR_W-1:0] addr;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rlast_o   = 1'b0;
    rdata_o   = '0;
    ar_cnt    = 0;
    resp_cnt  = 0;
    // Unloaded slots carry an unhandled opcode and their own index
    for (int i = 0; i < DEPTH; i++) begin
      wqe_tab[i] = {16{8'hee, 8'(i), 16'h5a5a}};
    end
    forever begin
      @(posedge clk_i);
      if (rstn_i && arvalid_i) begin
        arready_o <= 1'b1;
        @(posedge clk_i);                  // AR handshake
        arready_o <= 1'b0;
        addr = araddr_i;
        if (ar_cnt < DEPTH) begin
          ar_log[ar_cnt] = addr;
        end
        ar_cnt++;
        delay = resp_cnt % 3 + 1;          // 1 to 3 cycles
        resp_cnt++;
        idx = int'((addr - BASE_ADDR) >> WQE_ADDR_SHIFT);
        repeat (delay - 1) @(posedge clk_i);
        rvalid_o <= 1'b1;
        rlast_o  <= 1'b1;                  // Single beat per WQE
        rdata_o  <= wqe_tab[idx % DEPTH];
        do @(posedge clk_i); while (!rready_i);
        rvalid_o <= 1'b0;
        rlast_o  <= 1'b0;
      end
    end
  end

endmodule

//--- testbench/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk_o,
  output logic rstn_o
);

  // 20 unit period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    rstn_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rstn_o <= 1'b1;                        // Released on a rising edge
  end

endmodule

//--- rtl/wq_manager.sv
module wq_manager (
  input  logic                        axil_aclk_i,
  input  logic                        rstn_i,
  // Doorbell
  input  logic [wq_pkg::QP_IDX_W-1:0] qp_idx_i,
  input  logic [wq_pkg::IDX_W-1:0]    sq_prod_idx_i,
  input  logic [wq_pkg::ADDR_W-1:0]   sq_base_addr_i,
  input  logic [wq_pkg::ADDR_W-1:0]   local_vaddr_i,
  // QP configuration
  input  logic                        qp_configured_i,
  input  logic [31:0]                 qp_conf_i,
  input  logic [wq_pkg::QPN_W-1:0]    dest_qp_i,
  input  logic [wq_pkg::PSN_W-1:0]    sq_psn_i,
  input  logic [wq_pkg::PSN_W-1:0]    dest_sq_psn_i,
  // AXI read
  output logic                        arvalid_o,
  input  logic                        arready_i,
  output logic [wq_pkg::ADDR_W-1:0]   araddr_o,
  input  logic                        rvalid_i,
  input  logic [wq_pkg::WQE_W-1:0]    rdata_i,
  input  logic                        rlast_i,
  output logic                        rready_o,
  // RDMA core
  output logic                        sq_req_valid_o,
  input  logic                        sq_req_ready_i,
  output wq_pkg::rdma_req_t           sq_req_o,
  output logic                        qp_ctx_valid_o,
  input  logic                        qp_ctx_ready_i,
  output wq_pkg::qp_ctx_t             qp_ctx_o
);

  import wq_pkg::*;

  logic              fetch_req;
  logic [ADDR_W-1:0] fetch_addr;
  logic [ADDR_W-1:0] job_vaddr;
  logic              wqe_valid;
  logic [WQE_W-1:0]  wqe_data;
  logic              wqe_done;
  logic [IDX_W-1:0]  mtu;

  sq_doorbell i_sq_doorbell (
    .axil_aclk_i    (axil_aclk_i),
    .rstn_i         (rstn_i),
    .qp_idx_i       (qp_idx_i),
    .sq_prod_idx_i  (sq_prod_idx_i),
    .sq_base_addr_i (sq_base_addr_i),
    .local_vaddr_i  (local_vaddr_i),
    .wqe_done_i     (wqe_done),
    .fetch_req_o    (fetch_req),
    .fetch_addr_o   (fetch_addr),
    .job_vaddr_o    (job_vaddr)
  );

  qp_config i_qp_config (
    .axil_aclk_i     (axil_aclk_i),
    .rstn_i          (rstn_i),
    .qp_configured_i (qp_configured_i),
    .qp_idx_i        (qp_idx_i),
    .qp_conf_i       (qp_conf_i),
    .dest_qp_i       (dest_qp_i),
    .sq_psn_i        (sq_psn_i),
    .dest_sq_psn_i   (dest_sq_psn_i),
    .qp_ctx_ready_i  (qp_ctx_ready_i),
    .qp_ctx_valid_o  (qp_ctx_valid_o),
    .qp_ctx_o        (qp_ctx_o),
    .mtu_o           (mtu)
  );

  wqe_fetch i_wqe_fetch (
    .axil_aclk_i  (axil_aclk_i),
    .rstn_i       (rstn_i),
    .fetch_req_i  (fetch_req),
    .fetch_addr_i (fetch_addr),
    .arvalid_o    (arvalid_o),
    .arready_i    (arready_i),
    .araddr_o     (araddr_o),
    .rvalid_i     (rvalid_i),
    .rdata_i      (rdata_i),
    .rlast_i      (rlast_i),
    .rready_o     (rready_o),
    .wqe_valid_o  (wqe_valid),
    .wqe_data_o   (wqe_data)
  );

  sq_segmenter i_sq_segmenter (
    .axil_aclk_i    (axil_aclk_i),
    .rstn_i         (rstn_i),
    .wqe_valid_i    (wqe_valid),
    .wqe_data_i     (wqe_data),
    .job_vaddr_i    (job_vaddr),
    .mtu_i          (mtu),
    .sq_req_valid_o (sq_req_valid_o),
    .sq_req_ready_i (sq_req_ready_i),
    .sq_req_o       (sq_req_o),
    .wqe_done_o     (wqe_done)
  );

endmodule

//--- sq_segmenter/sq_segmenter.sv
module sq_segmenter (
  input  logic                      axil_aclk_i,
  input  logic                      rstn_i,
  input  logic                      wqe_valid_i,
  input  logic [wq_pkg::WQE_W-1:0]  wqe_data_i,
  input  logic [wq_pkg::ADDR_W-1:0] job_vaddr_i,
  input  logic [wq_pkg::IDX_W-1:0]  mtu_i,
  output logic                      sq_req_valid_o,
  input  logic                      sq_req_ready_i,
  output wq_pkg::rdma_req_t         sq_req_o,
  output logic                      wqe_done_o
);

  import wq_pkg::*;

  typedef enum logic {
    SG_IDLE,
    SG_REQ                                 // A request is on the port
  } sg_state_e;

  sg_state_e           state_q;
  logic                wqe_done_q;
  rdma_req_t           req_q;
  logic [IDX_W-1:0]    rem_len_q;          // Bytes after the current segment
  logic [ADDR_W-1:0]   loc_vaddr_q;
  logic [ADDR_W-1:0]   rem_vaddr_q;
  logic [WQE_OP_W-1:0] wqe_op;
  logic [IDX_W-1:0]    wqe_len;
  logic [ADDR_W-1:0]   wqe_rvaddr;
  logic [ADDR_W-1:0]   mtu_step;
  logic                is_write;
  logic                is_read;
  logic                start;
  logic                accept;
  logic                step;

  function automatic rdma_req_t make_req(
    input logic [REQ_OP_W-1:0] op,
    input logic                last,
    input logic [IDX_W-1:0]    len,
    input logic [ADDR_W-1:0]   lva,
    input logic [ADDR_W-1:0]   rva
  );
    rdma_req_t r;
    r.opcode       = op;
    r.last         = last;
    r.len          = len;
    r.local_vaddr  = lva;
    r.remote_vaddr = rva;
    return r;
  endfunction

  ////////////////////////////////////////
  // WQE decode
  ////////////////////////////////////////
  assign wqe_op     = wqe_data_i[WQE_OP_MSB:WQE_OP_LSB];
  assign wqe_len    = wqe_data_i[WQE_LEN_MSB:WQE_LEN_LSB];
  assign wqe_rvaddr = wqe_data_i[WQE_RVA_MSB:WQE_RVA_LSB];
  assign mtu_step   = ADDR_W'(mtu_i);

  assign is_write = (wqe_op == WQE_OP_WRITE);
  assign is_read  = (wqe_op == WQE_OP_READ);
  assign start    = (state_q == SG_IDLE) && wqe_valid_i && (is_write || is_read);
  assign accept   = sq_req_valid_o && sq_req_ready_i;
  assign step     = accept && !req_q.last;

  always_ff @(posedge axil_aclk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q    <= SG_IDLE;
      wqe_done_q <= 1'b0;
    end else begin
      wqe_done_q <= 1'b0;
      case (state_q)
        SG_IDLE: begin
          if (wqe_valid_i) begin
            if (is_write || is_read) begin
              state_q <= SG_REQ;
            end else begin
              wqe_done_q <= 1'b1;          // Unhandled opcode, just consume
            end
          end
        end
        SG_REQ: begin
          if (accept && req_q.last) begin
            state_q    <= SG_IDLE;
            wqe_done_q <= 1'b1;
          end
        end
        default: begin
          state_q <= SG_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Segment generation
  ////////////////////////////////////////
  always_ff @(posedge axil_aclk_i) begin
    if (start) begin
      if (is_read) begin
        req_q <= make_req(REQ_READ, 1'b1, wqe_len, job_vaddr_i, wqe_rvaddr);
      end else if (wqe_len <= mtu_i) begin
        req_q <= make_req(REQ_WRITE_ONLY, 1'b1, wqe_len, job_vaddr_i, wqe_rvaddr);
      end else begin
        req_q       <= make_req(REQ_WRITE_FIRST, 1'b0, mtu_i, job_vaddr_i, wqe_rvaddr);
        rem_len_q   <= wqe_len - mtu_i;
        loc_vaddr_q <= job_vaddr_i + mtu_step;
        rem_vaddr_q <= wqe_rvaddr + mtu_step;
      end
    end else if (step) begin
      if (rem_len_q <= mtu_i) begin
        // Remainder fits, close the message
        req_q <= make_req(REQ_WRITE_LAST, 1'b1, rem_len_q, loc_vaddr_q, rem_vaddr_q);
      end else begin
        req_q       <= make_req(REQ_WRITE_MIDDLE, 1'b0, mtu_i, loc_vaddr_q, rem_vaddr_q);
        rem_len_q   <= rem_len_q - mtu_i;
        loc_vaddr_q <= loc_vaddr_q + mtu_step;
        rem_vaddr_q <= rem_vaddr_q + mtu_step;
      end
    end
  end

  assign sq_req_valid_o = (state_q == SG_REQ);
  assign sq_req_o       = req_q;
  assign wqe_done_o     = wqe_done_q;

  // Back-pressure holds the request untouched
  assert property (@(posedge axil_aclk_i) disable iff (!rstn_i)
    sq_req_valid_o && !sq_req_ready_i |=> sq_req_valid_o && $stable(sq_req_o));

endmodule

//--- wqe_fetch/wqe_fetch.sv
module wqe_fetch (
  input  logic                      axil_aclk_i,
  input  logic                      rstn_i,
  input  logic                      fetch_req_i,
  input  logic [wq_pkg::ADDR_W-1:0] fetch_addr_i,
  // AR channel
  output logic                      arvalid_o,
  input  logic                      arready_i,
  output logic [wq_pkg::ADDR_W-1:0] araddr_o,
  // R channel
  input  logic                      rvalid_i,
  input  logic [wq_pkg::WQE_W-1:0]  rdata_i,
  input  logic                      rlast_i,
  output logic                      rready_o,
  // Fetched WQE
  output logic                      wqe_valid_o,
  output logic [wq_pkg::WQE_W-1:0]  wqe_data_o
);

  import wq_pkg::*;

  typedef enum logic [1:0] {
    FT_IDLE,
    FT_ADDR,                               // arvalid held
    FT_READ                                // rready held until last beat
  } ft_state_e;

  ft_state_e          state_q;
  logic               wqe_valid_q;
  logic [ADDR_W-1:0]  araddr_q;
  logic [WQE_W-1:0]   wqe_q;

  ////////////////////////////////////////
  // Read master FSM
  ////////////////////////////////////////
  always_ff @(posedge axil_aclk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q     <= FT_IDLE;
      wqe_valid_q <= 1'b0;
    end else begin
      wqe_valid_q <= 1'b0;
      case (state_q)
        FT_IDLE: begin
          if (fetch_req_i) begin
            state_q <= FT_ADDR;
          end
        end
        FT_ADDR: begin
          if (arready_i) begin
            state_q <= FT_READ;
          end
        end
        FT_READ: begin
          if (rvalid_i && rlast_i) begin
            state_q     <= FT_IDLE;
            wqe_valid_q <= 1'b1;           // One pulse per WQE
          end
        end
        default: begin
          state_q <= FT_IDLE;
        end
      endcase
    end
  end

  // Address and data holding registers
  always_ff @(posedge axil_aclk_i) begin
    if (state_q == FT_IDLE && fetch_req_i) begin
      araddr_q <= fetch_addr_i;
    end
    if (state_q == FT_READ && rvalid_i) begin
      wqe_q <= rdata_i;                    // Last beat wins
    end
  end

  assign arvalid_o   = (state_q == FT_ADDR);
  assign araddr_o    = araddr_q;
  assign rready_o    = (state_q == FT_READ);
  assign wqe_valid_o = wqe_valid_q;
  assign wqe_data_o  = wqe_q;

  // AXI rule, the address is not withdrawn or changed before arready
  assert property (@(posedge axil_aclk_i) disable iff (!rstn_i)
    arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o));

endmodule

//--- rtl/qp_config.sv
module qp_config (
  input  logic                        axil_aclk_i,
  input  logic                        rstn_i,
  input  logic                        qp_configured_i,
  input  logic [wq_pkg::QP_IDX_W-1:0] qp_idx_i,
  input  logic [31:0]                 qp_conf_i,
  input  logic [wq_pkg::QPN_W-1:0]    dest_qp_i,
  input  logic [wq_pkg::PSN_W-1:0]    sq_psn_i,
  input  logic [wq_pkg::PSN_W-1:0]    dest_sq_psn_i,
  input  logic                        qp_ctx_ready_i,
  output logic                        qp_ctx_valid_o,
  output wq_pkg::qp_ctx_t             qp_ctx_o,
  output logic [wq_pkg::IDX_W-1:0]    mtu_o
);

  import wq_pkg::*;

  logic                  ctx_valid_q;
  qp_ctx_t               ctx_q;
  logic [MTU_CODE_W-1:0] mtu_code_q;
  logic [MTU_CODE_W-1:0] conf_code;
  logic                  conf_ok;

  assign conf_code = qp_conf_i[QP_CONF_MTU_MSB:QP_CONF_MTU_LSB];

  // Enabled QP with a supported MTU, and no context still pending
  assign conf_ok = qp_configured_i && !ctx_valid_q &&
                   qp_conf_i[QP_CONF_EN_BIT] &&
                   (conf_code <= MTU_CODE_W'(MTU_CODE_MAX));

  always_ff @(posedge axil_aclk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      ctx_valid_q <= 1'b0;
      mtu_code_q  <= '0;                   // 256 byte MTU out of reset
    end else begin
      if (conf_ok) begin
        ctx_valid_q <= 1'b1;
        mtu_code_q  <= conf_code;
      end else if (ctx_valid_q && qp_ctx_ready_i) begin
        ctx_valid_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Context payload
  ////////////////////////////////////////
  always_ff @(posedge axil_aclk_i) begin
    if (conf_ok) begin
      ctx_q.qp_idx      <= qp_idx_i;
      ctx_q.dest_qp     <= dest_qp_i;
      ctx_q.sq_psn      <= sq_psn_i;
      ctx_q.dest_sq_psn <= dest_sq_psn_i;
      ctx_q.mtu_code    <= conf_code;
    end
  end

  assign qp_ctx_valid_o = ctx_valid_q;
  assign qp_ctx_o       = ctx_q;
  assign mtu_o          = IDX_W'(MTU_BASE) << mtu_code_q;   // Bytes

endmodule

//--- rtl/sq_doorbell.sv
module sq_doorbell (
  input  logic                        axil_aclk_i,
  input  logic                        rstn_i,
  input  logic [wq_pkg::QP_IDX_W-1:0] qp_idx_i,
  input  logic [wq_pkg::IDX_W-1:0]    sq_prod_idx_i,
  input  logic [wq_pkg::ADDR_W-1:0]   sq_base_addr_i,
  input  logic [wq_pkg::ADDR_W-1:0]   local_vaddr_i,
  input  logic                        wqe_done_i,
  output logic                        fetch_req_o,
  output logic [wq_pkg::ADDR_W-1:0]   fetch_addr_o,
  output logic [wq_pkg::ADDR_W-1:0]   job_vaddr_o
);

  import wq_pkg::*;

  logic [IDX_W-1:0]    local_idx_q [NUM_QP];
  logic                busy_q;
  logic                fetch_req_q;
  logic [QP_SEL_W-1:0] job_qp_q;
  logic [IDX_W-1:0]    job_prod_q;
  logic [ADDR_W-1:0]   job_base_q;
  logic [ADDR_W-1:0]   job_vaddr_q;
  logic [QP_SEL_W-1:0] db_qp;
  logic                db_hit;
  logic [IDX_W-1:0]    next_idx;

  assign db_qp = qp_idx_i[QP_SEL_W-1:0];

  // Level compare, so a doorbell raised while busy is picked up later
  assign db_hit = !busy_q && (qp_idx_i < QP_IDX_W'(NUM_QP)) &&
                  (sq_prod_idx_i > local_idx_q[db_qp]);

  assign next_idx = local_idx_q[job_qp_q] + 1'b1;

  always_ff @(posedge axil_aclk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      busy_q      <= 1'b0;
      fetch_req_q <= 1'b0;
      for (int i = 0; i < NUM_QP; i++) begin
        local_idx_q[i] <= '0;
      end
    end else begin
      fetch_req_q <= 1'b0;
      if (db_hit) begin
        busy_q      <= 1'b1;
        fetch_req_q <= 1'b1;               // First WQE of the job
      end else if (busy_q && wqe_done_i) begin
        local_idx_q[job_qp_q] <= next_idx;
        if (next_idx < job_prod_q) begin
          fetch_req_q <= 1'b1;
        end else begin
          busy_q <= 1'b0;                  // Caught up with the producer
        end
      end
    end
  end

  // Job snapshot
  always_ff @(posedge axil_aclk_i) begin
    if (db_hit) begin
      job_qp_q    <= db_qp;
      job_prod_q  <= sq_prod_idx_i;
      job_base_q  <= sq_base_addr_i;
      job_vaddr_q <= local_vaddr_i;
    end
  end

  // WQEs are 64 byte aligned slots behind the queue base
  assign fetch_addr_o = job_base_q + (ADDR_W'(local_idx_q[job_qp_q]) << WQE_ADDR_SHIFT);
  assign fetch_req_o  = fetch_req_q;
  assign job_vaddr_o  = job_vaddr_q;

  // Consumer index stays behind the doorbell that started the job
  assert property (@(posedge axil_aclk_i) disable iff (!rstn_i)
    busy_q |-> local_idx_q[job_qp_q] <= job_prod_q);

endmodule

//--- common/wq_pkg.sv
package wq_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////
  localparam int NUM_QP         = 8;
  localparam int QP_SEL_W       = $clog2(NUM_QP);  // Selects a local index entry
  localparam int QP_IDX_W       = 8;
  localparam int IDX_W          = 32;
  localparam int ADDR_W         = 64;
  localparam int WQE_BYTES      = 64;
  localparam int WQE_W          = WQE_BYTES * 8;
  localparam int WQE_ADDR_SHIFT = $clog2(WQE_BYTES);
  localparam int QPN_W          = 24;
  localparam int PSN_W          = 24;

  ////////////////////////////////////////
  // WQE layout
  ////////////////////////////////////////
  localparam int WQE_OP_W      = 8;
  localparam int WQE_OP_LSB    = 128;
  localparam int WQE_OP_MSB    = 135;
  localparam int WQE_LEN_LSB   = 96;
  localparam int WQE_LEN_MSB   = 127;
  localparam int WQE_RVA_LSB   = 160;
  localparam int WQE_RVA_MSB   = 223;

  localparam logic [WQE_OP_W-1:0] WQE_OP_WRITE = 8'h00;
  localparam logic [WQE_OP_W-1:0] WQE_OP_READ  = 8'h04;

  ////////////////////////////////////////
  // Request opcodes towards the RDMA core
  ////////////////////////////////////////
  localparam int REQ_OP_W = 5;

  localparam logic [REQ_OP_W-1:0] REQ_WRITE_FIRST  = 5'h06;
  localparam logic [REQ_OP_W-1:0] REQ_WRITE_MIDDLE = 5'h07;
  localparam logic [REQ_OP_W-1:0] REQ_WRITE_LAST   = 5'h08;
  localparam logic [REQ_OP_W-1:0] REQ_WRITE_ONLY   = 5'h0a;
  localparam logic [REQ_OP_W-1:0] REQ_READ         = 5'h0c;

  ////////////////////////////////////////
  // QP configuration word
  ////////////////////////////////////////
  localparam int MTU_BASE        = 256;   // Bytes at code 0
  localparam int MTU_CODE_MAX    = 4;     // 4096 bytes
  localparam int MTU_CODE_W      = 3;
  localparam int QP_CONF_EN_BIT  = 0;
  localparam int QP_CONF_MTU_LSB = 8;
  localparam int QP_CONF_MTU_MSB = 10;

  typedef struct packed {
    logic [REQ_OP_W-1:0] opcode;
    logic                last;          // Final request of the WQE
    logic [IDX_W-1:0]    len;
    logic [ADDR_W-1:0]   local_vaddr;
    logic [ADDR_W-1:0]   remote_vaddr;
  } rdma_req_t;

  typedef struct packed {
    logic [QP_IDX_W-1:0]   qp_idx;
    logic [QPN_W-1:0]      dest_qp;
    logic [PSN_W-1:0]      sq_psn;
    logic [PSN_W-1:0]      dest_sq_psn;
    logic [MTU_CODE_W-1:0] mtu_code;
  } qp_ctx_t;

endpackage
